//--- tiny_cpu_pkg.sv
package tiny_cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    localparam word_t DEFAULT_RESET_VECTOR = 32'h0000_0100;

    localparam reg_idx_t REG_ZERO = 4'd0;
    localparam reg_idx_t REG_PC   = 4'd15;

    localparam logic [3:0] CLASS_ILLEGAL = 4'b1111;

    // Operation applied to X and O, before the addend
    typedef enum logic [3:0] {
        OP_OR   = 4'd0,
        OP_AND  = 4'd1,
        OP_ADD  = 4'd2,
        OP_MUL  = 4'd3,
        OP_RSVD = 4'd4,  // Gives zero
        OP_SHL  = 4'd5,
        OP_LE   = 4'd6,  // Signed
        OP_EQ   = 4'd7,
        OP_NOR  = 4'd8,
        OP_NAND = 4'd9,
        OP_XOR  = 4'd10,
        OP_SUB  = 4'd11,
        OP_XNOR = 4'd12,
        OP_SHR  = 4'd13, // Logical
        OP_GT   = 4'd14, // Signed
        OP_NE   = 4'd15
    } alu_op_e;

    // What happens with rhs
    typedef enum logic [1:0] {
        DEREF_REG_WRITE = 2'b00, // Z <- rhs
        DEREF_LOAD      = 2'b01, // Z <- [rhs]
        DEREF_STORE_RHS = 2'b10, // [Z] <- rhs
        DEREF_STORE_Z   = 2'b11  // [rhs] <- Z
    } deref_e;

    // Execution view of an instruction word
    typedef struct packed {
        logic        cls;   // 0 for normal instructions
        logic        itype; // 1 swaps immediate and Y
        deref_e      deref;
        reg_idx_t    z;
        reg_idx_t    x;
        reg_idx_t    y;
        alu_op_e     op;
        logic [11:0] imm;
    } insn_fields_t;

    // Legality view of the same word
    typedef struct packed {
        logic [3:0]  nibble;
        logic [27:0] payload;
    } insn_class_t;

    typedef union packed {
        insn_fields_t f;
        insn_class_t  c;
    } insn_word_u;

    // Decoder output, shared by the datapath and control
    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic        itype;
        deref_e      deref;
        reg_idx_t    z;
        reg_idx_t    x;
        reg_idx_t    y;
        alu_op_e     op;
        logic [11:0] imm;
    } decoded_t;

endpackage

//--- reg_file.sv
module reg_file (
    input  logic                 reset_n,   // Clock
    input  logic                 i_reset_n, // Sync reset, active high
    input  tiny_cpu_pkg::reg_idx_t i_rd_x,
    input  tiny_cpu_pkg::reg_idx_t i_rd_y,
    input  tiny_cpu_pkg::reg_idx_t i_rd_z,
    output tiny_cpu_pkg::word_t    o_val_x,
    output tiny_cpu_pkg::word_t    o_val_y,
    output tiny_cpu_pkg::word_t    o_val_z,
    input  tiny_cpu_pkg::word_t    i_pc,
    input  logic                   i_we,
    input  tiny_cpu_pkg::reg_idx_t i_wr_idx,
    input  tiny_cpu_pkg::word_t    i_wr_data
);

    // Only the general registers live here
    tiny_cpu_pkg::word_t regs [1:14];

    logic wr_ok;

    function automatic tiny_cpu_pkg::word_t read_reg(input tiny_cpu_pkg::reg_idx_t idx);
        tiny_cpu_pkg::word_t val;
        if (idx == tiny_cpu_pkg::REG_ZERO) begin
            val = '0;
        end else if (idx == tiny_cpu_pkg::REG_PC) begin
            val = i_pc; // Current instruction address
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    // Reads follow both the indices and the array contents
    always_comb begin
        o_val_x = read_reg(i_rd_x);
        o_val_y = read_reg(i_rd_y);
        o_val_z = read_reg(i_rd_z);
    end

    // Index 0 and 15 never reach the array
    assign wr_ok = i_we
                && (i_wr_idx != tiny_cpu_pkg::REG_ZERO)
                && (i_wr_idx != tiny_cpu_pkg::REG_PC);

    always_ff @(posedge reset_n) begin
        if (i_reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

endmodule

//--- insn_decode.sv
module insn_decode (
    input  tiny_cpu_pkg::word_t    i_insn,
    output tiny_cpu_pkg::decoded_t o_dec
);

    tiny_cpu_pkg::insn_word_u word;

    logic is_illegal;
    logic is_normal;

    assign word = i_insn;

    // Top nibble 1111 halts, class bit 0 executes, the rest are no-ops
    assign is_illegal = (word.c.nibble == tiny_cpu_pkg::CLASS_ILLEGAL);
    assign is_normal  = ~word.f.cls;

    always_comb begin
        o_dec = '0;
        if (is_illegal) begin
            o_dec.valid   = 1'b1;
            o_dec.illegal = 1'b1;
        end else if (is_normal) begin
            o_dec.valid = 1'b1;
            o_dec.itype = word.f.itype;
            o_dec.deref = word.f.deref;
            o_dec.z     = word.f.z;
            o_dec.x     = word.f.x;
            o_dec.y     = word.f.y;
            o_dec.op    = word.f.op;
            o_dec.imm   = word.f.imm;
        end
    end

endmodule

//--- alu_exec.sv
module alu_exec (
    input  tiny_cpu_pkg::decoded_t i_dec,
    input  tiny_cpu_pkg::word_t    i_val_x,
    input  tiny_cpu_pkg::word_t    i_val_y,
    output tiny_cpu_pkg::word_t    o_rhs
);

    tiny_cpu_pkg::word_t imm_sext;
    tiny_cpu_pkg::word_t opnd_o;  // Right operand of the op
    tiny_cpu_pkg::word_t addend;
    tiny_cpu_pkg::word_t op_res;

    logic [4:0] shamt;

    assign imm_sext = {{20{i_dec.imm[11]}}, i_dec.imm};

    // Type 1 swaps the roles of Y and the immediate
    assign opnd_o = i_dec.itype ? imm_sext : i_val_y;
    assign addend = i_dec.itype ? i_val_y  : imm_sext;
    assign shamt  = opnd_o[4:0];

    always_comb begin
        case (i_dec.op)
            tiny_cpu_pkg::OP_OR:   op_res = i_val_x | opnd_o;
            tiny_cpu_pkg::OP_AND:  op_res = i_val_x & opnd_o;
            tiny_cpu_pkg::OP_ADD:  op_res = i_val_x + opnd_o;
            tiny_cpu_pkg::OP_MUL:  op_res = i_val_x * opnd_o; // Low 32 bits
            tiny_cpu_pkg::OP_SHL:  op_res = i_val_x << shamt;
            tiny_cpu_pkg::OP_LE: begin
                op_res = {31'b0, $signed(i_val_x) <= $signed(opnd_o)};
            end
            tiny_cpu_pkg::OP_EQ:   op_res = {31'b0, i_val_x == opnd_o};
            tiny_cpu_pkg::OP_NOR:  op_res = ~(i_val_x | opnd_o);
            tiny_cpu_pkg::OP_NAND: op_res = ~(i_val_x & opnd_o);
            tiny_cpu_pkg::OP_XOR:  op_res = i_val_x ^ opnd_o;
            tiny_cpu_pkg::OP_SUB:  op_res = i_val_x - opnd_o;
            tiny_cpu_pkg::OP_XNOR: op_res = ~(i_val_x ^ opnd_o);
            tiny_cpu_pkg::OP_SHR:  op_res = i_val_x >> shamt;
            tiny_cpu_pkg::OP_GT: begin
                op_res = {31'b0, $signed(i_val_x) > $signed(opnd_o)};
            end
            tiny_cpu_pkg::OP_NE:   op_res = {31'b0, i_val_x != opnd_o};
            default:               op_res = '0; // Reserved op
        endcase
    end

    // No-op words produce a zero result
    assign o_rhs = i_dec.valid ? (op_res + addend) : '0;

endmodule

//--- core_ctrl.sv
module core_ctrl #(
    parameter tiny_cpu_pkg::word_t RESET_VECTOR = tiny_cpu_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic                   reset_n,   // Clock
    input  logic                   i_reset_n, // Sync reset, active high
    input  tiny_cpu_pkg::decoded_t i_dec,
    input  tiny_cpu_pkg::word_t    i_rhs,
    input  tiny_cpu_pkg::word_t    i_val_z,
    input  tiny_cpu_pkg::word_t    i_mem_rdata,
    output tiny_cpu_pkg::word_t    o_pc,
    output tiny_cpu_pkg::word_t    o_insn_addr,
    output logic                   o_reg_we,
    output tiny_cpu_pkg::reg_idx_t o_wr_idx,
    output tiny_cpu_pkg::word_t    o_wr_data,
    output tiny_cpu_pkg::word_t    o_mem_addr,
    output tiny_cpu_pkg::word_t    o_mem_wdata,
    output logic                   o_mem_we,
    output logic                   o_mem_re,
    output logic                   o_halt
);

    tiny_cpu_pkg::word_t pc;
    tiny_cpu_pkg::word_t pc_next;

    logic halt;
    logic active;     // Instruction has architectural effect
    logic is_wb;      // Reg write or load
    logic is_store;
    logic is_load;
    logic z_general;  // Z is one of registers 1 to 14
    logic jump;

    assign active = i_dec.valid & ~i_dec.illegal & ~halt;

    assign is_load  = (i_dec.deref == tiny_cpu_pkg::DEREF_LOAD);
    assign is_wb    = (i_dec.deref == tiny_cpu_pkg::DEREF_REG_WRITE) | is_load;
    assign is_store = i_dec.deref[1];

    assign z_general = (i_dec.z != tiny_cpu_pkg::REG_ZERO)
                    && (i_dec.z != tiny_cpu_pkg::REG_PC);

    // Register write-back
    assign o_wr_idx  = i_dec.z;
    assign o_wr_data = is_load ? i_mem_rdata : i_rhs;
    assign o_reg_we  = active & is_wb & z_general;

    // Writing register 15 is a jump
    assign jump = active & is_wb & (i_dec.z == tiny_cpu_pkg::REG_PC);

    // Data memory strobes and operands
    assign o_mem_re = active & is_load;
    assign o_mem_we = active & is_store;

    always_comb begin
        case (i_dec.deref)
            tiny_cpu_pkg::DEREF_STORE_RHS: begin
                o_mem_addr  = i_val_z; // Address held in Z
                o_mem_wdata = i_rhs;
            end
            tiny_cpu_pkg::DEREF_STORE_Z: begin
                o_mem_addr  = i_rhs;
                o_mem_wdata = i_val_z;
            end
            default: begin
                o_mem_addr  = i_rhs;   // Load address
                o_mem_wdata = i_val_z;
            end
        endcase
    end

    always_comb begin
        pc_next = pc + 32'd1;
        if (halt || i_dec.illegal) begin
            pc_next = pc;  // Stop advancing
        end else if (jump) begin
            pc_next = o_wr_data;
        end
    end

    always_ff @(posedge reset_n) begin
        if (i_reset_n) begin
            pc   <= RESET_VECTOR;
            halt <= 1'b0;
        end else begin
            pc   <= pc_next;
            halt <= halt | i_dec.illegal;
        end
    end

    assign o_pc        = pc;
    assign o_halt      = halt;
    assign o_insn_addr = halt ? RESET_VECTOR : pc; // Parked while halted

endmodule

//--- tiny_core.sv
module tiny_core #(
    parameter tiny_cpu_pkg::word_t RESET_VECTOR = tiny_cpu_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic                reset_n,    // Clock
    input  logic                i_reset_n,  // Sync reset, active high
    output tiny_cpu_pkg::word_t o_insn_addr,
    input  tiny_cpu_pkg::word_t i_insn_data,
    output tiny_cpu_pkg::word_t o_mem_addr,
    output tiny_cpu_pkg::word_t o_mem_wdata,
    output logic                o_mem_we,
    output logic                o_mem_re,
    input  tiny_cpu_pkg::word_t i_mem_rdata,
    output logic                o_halt
);

    tiny_cpu_pkg::decoded_t dec;

    tiny_cpu_pkg::word_t val_x;
    tiny_cpu_pkg::word_t val_y;
    tiny_cpu_pkg::word_t val_z;
    tiny_cpu_pkg::word_t rhs;
    tiny_cpu_pkg::word_t pc;
    tiny_cpu_pkg::word_t wr_data;

    tiny_cpu_pkg::reg_idx_t wr_idx;

    logic reg_we;

    insn_decode u_insn_decode (
        .i_insn (i_insn_data),
        .o_dec  (dec)
    );

    reg_file u_reg_file (
        .reset_n   (reset_n),
        .i_reset_n (i_reset_n),
        .i_rd_x    (dec.x),
        .i_rd_y    (dec.y),
        .i_rd_z    (dec.z),
        .o_val_x   (val_x),
        .o_val_y   (val_y),
        .o_val_z   (val_z),
        .i_pc      (pc),
        .i_we      (reg_we),
        .i_wr_idx  (wr_idx),
        .i_wr_data (wr_data)
    );

    alu_exec u_alu_exec (
        .i_dec   (dec),
        .i_val_x (val_x),
        .i_val_y (val_y),
        .o_rhs   (rhs)
    );

    core_ctrl #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_core_ctrl (
        .reset_n     (reset_n),
        .i_reset_n   (i_reset_n),
        .i_dec       (dec),
        .i_rhs       (rhs),
        .i_val_z     (val_z),
        .i_mem_rdata (i_mem_rdata),
        .o_pc        (pc),
        .o_insn_addr (o_insn_addr),
        .o_reg_we    (reg_we),
        .o_wr_idx    (wr_idx),
        .o_wr_data   (wr_data),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_we    (o_mem_we),
        .o_mem_re    (o_mem_re),
        .o_halt      (o_halt)
    );

endmodule

//--- tb_tiny_core.sv
module tb_tiny_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam tiny_cpu_pkg::word_t RESET_VECTOR = tiny_cpu_pkg::DEFAULT_RESET_VECTOR;
    localparam int IMEM_WORDS = 512;
    localparam int DMEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = 2000; // Far above the ~150 cycles of all tests
    localparam tiny_cpu_pkg::word_t ILLEGAL_WORD = 32'hF000_0000;
    localparam tiny_cpu_pkg::word_t NOP_WORD     = 32'h8000_0000;

    logic reset_n;    // Clock
    logic core_reset; // Sync reset, active high
    logic mem_we;
    logic mem_re;
    logic halt;

    tiny_cpu_pkg::word_t insn_addr;
    tiny_cpu_pkg::word_t insn_data;
    tiny_cpu_pkg::word_t mem_addr;
    tiny_cpu_pkg::word_t mem_wdata;
    tiny_cpu_pkg::word_t mem_rdata;

    tiny_cpu_pkg::word_t imem [0:IMEM_WORDS-1];
    tiny_cpu_pkg::word_t dmem [0:DMEM_WORDS-1];

    // Stores seen on the bus and stores the rules predict
    tiny_cpu_pkg::word_t got_addr [$];
    tiny_cpu_pkg::word_t got_data [$];
    tiny_cpu_pkg::word_t exp_addr [$];
    tiny_cpu_pkg::word_t exp_data [$];

    int prog_len = 0;
    int load_count = 0;
    int mismatch_count = 0;
    int other_errors = 0;
    int cycle_count = 0;

    tiny_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_tiny_core (
        .reset_n     (reset_n),
        .i_reset_n   (core_reset),
        .o_insn_addr (insn_addr),
        .i_insn_data (insn_data),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_we    (mem_we),
        .o_mem_re    (mem_re),
        .i_mem_rdata (mem_rdata),
        .o_halt      (halt)
    );

    function automatic tiny_cpu_pkg::word_t fill_word(input tiny_cpu_pkg::word_t addr);
        return addr ^ 32'hC3A5_5A3C;
    endfunction

    // Both memories answer within the cycle
    assign insn_data = (insn_addr < IMEM_WORDS) ? imem[insn_addr[8:0]] : ILLEGAL_WORD;
    assign mem_rdata = (mem_addr < DMEM_WORDS) ? dmem[mem_addr[7:0]] : fill_word(mem_addr);

    initial begin
        reset_n = 1'b0;
        forever #5 reset_n = ~reset_n;
    end

    // Store monitor, sampled on the rising edge
    always @(posedge reset_n) begin
        if (!core_reset) begin
            if (mem_we && mem_re) begin
                other_errors++;
                $display("Error: write and read strobes both high at address %h", mem_addr);
            end
            if (halt && (mem_we || mem_re)) begin
                other_errors++;
                $display("Error: memory strobe asserted while the core is halted");
            end
            if (mem_we) begin
                got_addr.push_back(mem_addr);
                got_data.push_back(mem_wdata);
                if (mem_addr < DMEM_WORDS) begin
                    dmem[mem_addr[7:0]] = mem_wdata;
                end
            end
            if (mem_re) begin
                load_count++;
            end
        end
    end

    function automatic tiny_cpu_pkg::word_t encode_insn(
        input logic                   itype,
        input logic [1:0]             deref,
        input tiny_cpu_pkg::reg_idx_t z,
        input tiny_cpu_pkg::reg_idx_t x,
        input tiny_cpu_pkg::reg_idx_t y,
        input logic [3:0]             op,
        input logic [11:0]            imm
    );
        return {1'b0, itype, deref, z, x, y, op, imm};
    endfunction

    // Z <- [addr], with rhs = (r0 | r0) + addr
    function automatic tiny_cpu_pkg::word_t load_word_insn(
        input tiny_cpu_pkg::reg_idx_t z, input logic [11:0] addr);
        return encode_insn(1'b0, tiny_cpu_pkg::DEREF_LOAD, z, 4'd0, 4'd0,
                           tiny_cpu_pkg::OP_OR, addr);
    endfunction

    function automatic tiny_cpu_pkg::word_t store_reg_insn(
        input tiny_cpu_pkg::reg_idx_t z, input logic [11:0] addr);
        return encode_insn(1'b0, tiny_cpu_pkg::DEREF_STORE_Z, z, 4'd0, 4'd0,
                           tiny_cpu_pkg::OP_OR, addr);
    endfunction

    function automatic tiny_cpu_pkg::word_t set_reg_insn(
        input tiny_cpu_pkg::reg_idx_t z, input logic [11:0] imm);
        return encode_insn(1'b0, tiny_cpu_pkg::DEREF_REG_WRITE, z, 4'd0, 4'd0,
                           tiny_cpu_pkg::OP_OR, imm);
    endfunction

    function automatic tiny_cpu_pkg::word_t sign_extend(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Expected op result from the instruction set rules
    function automatic tiny_cpu_pkg::word_t apply_op(
        input logic [3:0] op, input tiny_cpu_pkg::word_t x, input tiny_cpu_pkg::word_t o);
        tiny_cpu_pkg::word_t r;
        case (op)
            4'd0:  r = x | o;
            4'd1:  r = x & o;
            4'd2:  r = x + o;
            4'd3:  r = x * o;
            4'd4:  r = '0;
            4'd5:  r = x << o[4:0];
            4'd6:  r = ($signed(x) <= $signed(o)) ? 32'd1 : 32'd0;
            4'd7:  r = (x == o) ? 32'd1 : 32'd0;
            4'd8:  r = ~(x | o);
            4'd9:  r = ~(x & o);
            4'd10: r = x ^ o;
            4'd11: r = x - o;
            4'd12: r = ~(x ^ o);
            4'd13: r = x >> o[4:0];
            4'd14: r = ($signed(x) > $signed(o)) ? 32'd1 : 32'd0;
            4'd15: r = (x != o) ? 32'd1 : 32'd0;
        endcase
        return r;
    endfunction

    task automatic check_eq(input string name, input tiny_cpu_pkg::word_t expected,
                            input tiny_cpu_pkg::word_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = ILLEGAL_WORD; // Runaway fetch halts the core
        end
        prog_len = 0;
    endtask

    task automatic emit(input tiny_cpu_pkg::word_t insn);
        tiny_cpu_pkg::word_t addr;
        addr = RESET_VECTOR + 32'(prog_len);
        imem[addr[8:0]] = insn;
        prog_len++;
    endtask

    task automatic pulse_reset();
        @(negedge reset_n);
        core_reset = 1'b1;
        repeat (4) @(negedge reset_n);
        got_addr.delete();
        got_data.delete();
        load_count = 0;
        core_reset = 1'b0;
        check_eq("reset fetch address", RESET_VECTOR, insn_addr);
        check_eq("reset halt level", 32'd0, {31'b0, halt});
    endtask

    task automatic run_to_halt();
        while (!halt) begin
            @(negedge reset_n);
        end
    endtask

    task automatic expect_store(input tiny_cpu_pkg::word_t addr,
                                input tiny_cpu_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic compare_stores(input string name);
        int n;
        check_eq({name, " store count"}, 32'(exp_addr.size()), 32'(got_addr.size()));
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_eq($sformatf("%s store %0d address", name, i), exp_addr[i], got_addr[i]);
            check_eq($sformatf("%s store %0d data", name, i), exp_data[i], got_data[i]);
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic fetch_after_reset();
        clear_program();
        emit(set_reg_insn(4'd1, 12'h011));
        emit(NOP_WORD);
        emit(set_reg_insn(4'd2, 12'h022));
        emit(32'hB100_0080); // Class bit set, its fields would store r1 at 0x80
        emit(set_reg_insn(4'd3, 12'h033));
        emit(NOP_WORD);
        pulse_reset();
        for (int k = 0; k < 6; k++) begin
            check_eq("fetch sequence", RESET_VECTOR + 32'(k), insn_addr);
            @(negedge reset_n);
        end
        run_to_halt();
        compare_stores("fetch");
    endtask

    task automatic alu_type0_ops();
        tiny_cpu_pkg::word_t a;
        tiny_cpu_pkg::word_t b;
        logic [11:0] imm;
        clear_program();
        a = $urandom;
        b = $urandom;
        dmem[8'h10] = a;
        dmem[8'h11] = b;
        emit(load_word_insn(4'd1, 12'h010));
        emit(load_word_insn(4'd2, 12'h011));
        for (int op = 0; op < 16; op++) begin
            imm = 12'($urandom);
            emit(encode_insn(1'b0, tiny_cpu_pkg::DEREF_REG_WRITE, 4'd3, 4'd1, 4'd2, 4'(op), imm));
            emit(store_reg_insn(4'd3, 12'h040 + 12'(op)));
            expect_store(32'h40 + 32'(op), apply_op(4'(op), a, b) + sign_extend(imm));
        end
        pulse_reset();
        run_to_halt();
        compare_stores("type 0 ops");
    endtask

    task automatic alu_type1_swap();
        logic [3:0] ops [6] = '{tiny_cpu_pkg::OP_ADD, tiny_cpu_pkg::OP_SUB, tiny_cpu_pkg::OP_SHL,
                                tiny_cpu_pkg::OP_SHR, tiny_cpu_pkg::OP_LE, tiny_cpu_pkg::OP_GT};
        tiny_cpu_pkg::word_t a;
        tiny_cpu_pkg::word_t b;
        logic [11:0] imm;
        clear_program();
        a = $urandom;
        b = $urandom;
        dmem[8'h10] = a;
        dmem[8'h11] = b;
        emit(load_word_insn(4'd1, 12'h010));
        emit(load_word_insn(4'd2, 12'h011));
        for (int i = 0; i < 6; i++) begin
            imm = {1'b1, 11'($urandom)}; // Negative immediate as O
            emit(encode_insn(1'b1, tiny_cpu_pkg::DEREF_REG_WRITE, 4'd3, 4'd1, 4'd2, ops[i], imm));
            emit(store_reg_insn(4'd3, 12'h048 + 12'(i)));
            expect_store(32'h48 + 32'(i), apply_op(ops[i], a, sign_extend(imm)) + b);
        end
        pulse_reset();
        run_to_halt();
        compare_stores("type 1 swap");
    endtask

    task automatic deref_modes();
        tiny_cpu_pkg::word_t a;
        tiny_cpu_pkg::word_t b;
        tiny_cpu_pkg::word_t c;
        clear_program();
        a = $urandom;
        b = $urandom;
        c = $urandom;
        dmem[8'h10] = a;
        dmem[8'h11] = b;
        dmem[8'h12] = c;
        emit(load_word_insn(4'd1, 12'h010));
        emit(load_word_insn(4'd2, 12'h011));
        emit(load_word_insn(4'd5, 12'h012));
        emit(set_reg_insn(4'd4, 12'h050));
        // [r4] <- r1 + r2 + 5
        emit(encode_insn(1'b0, tiny_cpu_pkg::DEREF_STORE_RHS, 4'd4, 4'd1, 4'd2,
                         tiny_cpu_pkg::OP_ADD, 12'h005));
        // [r4 + 3] <- r5
        emit(encode_insn(1'b0, tiny_cpu_pkg::DEREF_STORE_Z, 4'd5, 4'd4, 4'd0,
                         tiny_cpu_pkg::OP_ADD, 12'h003));
        emit(load_word_insn(4'd6, 12'h050)); // Reads back the first store
        emit(store_reg_insn(4'd6, 12'h054));
        expect_store(32'h50, a + b + 32'd5);
        expect_store(32'h53, c);
        expect_store(32'h54, a + b + 32'd5);
        pulse_reset();
        run_to_halt();
        check_eq("deref load count", 32'd4, 32'(load_count));
        compare_stores("deref modes");
    endtask

    task automatic special_registers();
        clear_program();
        emit(set_reg_insn(4'd0, 12'h7FF));
        emit(store_reg_insn(4'd0, 12'h060));
        // pc <- pc + 4, skipping three illegal words
        emit(encode_insn(1'b0, tiny_cpu_pkg::DEREF_REG_WRITE, 4'd15, 4'd15, 4'd0,
                         tiny_cpu_pkg::OP_ADD, 12'd4));
        prog_len = 6;
        emit(store_reg_insn(4'd15, 12'h061));
        emit(encode_insn(1'b0, tiny_cpu_pkg::DEREF_REG_WRITE, 4'd6, 4'd15, 4'd0,
                         tiny_cpu_pkg::OP_OR, 12'd0));
        emit(store_reg_insn(4'd6, 12'h062));
        expect_store(32'h60, 32'd0);
        expect_store(32'h61, RESET_VECTOR + 32'd6);
        expect_store(32'h62, RESET_VECTOR + 32'd7);
        pulse_reset();
        repeat (3) @(negedge reset_n);
        check_eq("jump target fetch", RESET_VECTOR + 32'd6, insn_addr);
        run_to_halt();
        compare_stores("special registers");
    endtask

    task automatic halt_and_recover();
        clear_program();
        emit(store_reg_insn(4'd2, 12'h070)); // r2 still zero here
        emit(set_reg_insn(4'd2, 12'h5A5));
        emit(store_reg_insn(4'd2, 12'h071));
        emit(ILLEGAL_WORD);
        pulse_reset();
        run_to_halt();
        // Parked fetch shows the first store, which must stay silent
        repeat (8) begin
            @(negedge reset_n);
            check_eq("halted fetch address", RESET_VECTOR, insn_addr);
            check_eq("halt level", 32'd1, {31'b0, halt});
        end
        expect_store(32'h70, 32'd0);
        expect_store(32'h71, 32'h5A5);
        compare_stores("before halt");
        pulse_reset();
        run_to_halt();
        expect_store(32'h70, 32'd0);
        expect_store(32'h71, 32'h5A5);
        compare_stores("after recovery");
    endtask

    task automatic finish_run();
        $display("Checks done with %0d mismatches and %0d other errors",
                 mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge reset_n);
            cycle_count++;
        end
        other_errors++;
        $display("Error: timeout after %0d cycles, the core never halted", cycle_count);
        finish_run();
    end

    initial begin
        void'($urandom(32'h59c32fc9));
        core_reset = 1'b1;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(32'(i));
        end
        clear_program();
        fetch_after_reset();
        alu_type0_ops();
        alu_type1_swap();
        deref_modes();
        special_registers();
        halt_and_recover();
        finish_run();
    end

endmodule

//--- src.f
tiny_cpu_pkg.sv
reg_file.sv
insn_decode.sv
alu_exec.sv
core_ctrl.sv
tiny_core.sv
tb_tiny_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tiny_core
LINT_TOP  ?= tiny_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
